// File: Makefile
VERILATOR  ?= verilator
TOP        := odd_pipe_tb
FILELIST   := odd_pipe.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors
FAIL_MSG   := Finished with errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // element widths of the quadword datapath
    localparam int QUAD_BITS = 128;
    localparam int BYTE_BITS = 8;
    localparam int HALF_BITS = 16;
    localparam int WORD_BITS = 32;
    localparam int QUAD_BYTES = QUAD_BITS / BYTE_BITS;

    // instruction field widths
    localparam int REG_ADDR_BITS = 7;
    localparam int IMM_BITS = 16;

    // bit 0 is the most significant bit in every vector below
    typedef logic [0:QUAD_BITS-1] quad_t;
    typedef logic [0:WORD_BITS-1] word_t;
    typedef logic [0:REG_ADDR_BITS-1] reg_addr_t;

    // I7, I10 and I16 all sit right-aligned in this field
    typedef logic [0:IMM_BITS-1] imm_t;

    // local store geometry
    localparam int LS_BYTES = 16384;
    localparam int LS_ADDR_BITS = 14;
    localparam int QUAD_ALIGN_BITS = 4;
    localparam int LS_LINES = LS_BYTES >> QUAD_ALIGN_BITS;
    localparam int LS_LINE_BITS = LS_ADDR_BITS - QUAD_ALIGN_BITS;

    typedef logic [0:LS_ADDR_BITS-1] ls_addr_t;
    typedef logic [0:LS_LINE_BITS-1] ls_line_t;

    localparam ls_addr_t LSLR = ls_addr_t'(LS_BYTES - 1);
    localparam ls_addr_t QUAD_MASK = ~ls_addr_t'((1 << QUAD_ALIGN_BITS) - 1);

    // RR/RI7 opcodes are 11 bits, RI10 and RI16 ones are padded with zeros on the right
    typedef enum logic [10:0] {
        SHIFT_LEFT_QUADWORD_BY_BITS           = 11'b00111011011,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE = 11'b00111111011,
        SHIFT_LEFT_QUADWORD_BY_BYTES          = 11'b00111011111,
        SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE = 11'b00111111111,
        ROTATE_QUADWORD_BY_BYTES              = 11'b00111011100,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE    = 11'b00111111100,
        ROTATE_QUADWORD_BY_BITS               = 11'b00111011000,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE     = 11'b00111111000,
        GATHER_BITS_FROM_BYTES                = 11'b00110110010,
        GATHER_BITS_FROM_HALFWORDS            = 11'b00110110001,
        GATHER_BITS_FROM_WORDS                = 11'b00110110000,
        LOAD_QUADWORD_DFORM                   = 11'b00110100000,
        LOAD_QUADWORD_AFORM                   = 11'b00110000100,
        STORE_QUADWORD_DFORM                  = 11'b00100100000,
        STORE_QUADWORD_AFORM                  = 11'b00100000100
    } opcode_e;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        PERMUTE    = 3'd5,
        LOAD_STORE = 3'd6
    } unit_id_e;

    // latency tag carried with each result record
    typedef logic [0:3] lat_t;

    localparam lat_t LAT_PERMUTE = 4'd4;
    localparam lat_t LAT_LOAD_STORE = 4'd7;

    // instruction with its operands already read
    typedef struct packed {
        opcode_e   opcode;
        quad_t     ra;
        quad_t     rb;
        quad_t     store_data;
        reg_addr_t rt_addr;
        imm_t      imm;
    } issue_t;

    // 143 bit record, unit id first
    typedef struct packed {
        unit_id_e  unit_id;
        quad_t     rt_value;
        logic      wr_en;
        reg_addr_t rt_addr;
        lat_t      latency;
    } result_t;

    localparam int ISSUE_STAGES = 1;
    localparam int UNIT_STAGES = 1;
    localparam int FORWARD_STAGES = 4;
    localparam int PIPE_LATENCY = ISSUE_STAGES + UNIT_STAGES + FORWARD_STAGES;

    // free slots in the consumer's result buffer
    localparam int RESULT_CREDITS = 4;
    typedef logic [0:2] credit_cnt_t;

endpackage

`default_nettype wire

// File: loadstore/ls_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ls_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    issue_valid,
    input  issue_t  issue,
    output logic    result_valid,
    output result_t result
);

    logic     is_load;
    logic     is_store;
    logic     a_form;
    word_t    d_offset;
    word_t    a_offset;
    word_t    ea;
    ls_addr_t ls_addr;
    ls_line_t line;

    // local store, one quadword per line
    quad_t    mem [0:LS_LINES-1];

    always_comb
    begin
        is_load = 1'b0;
        is_store = 1'b0;
        a_form = 1'b0;
        case (issue.opcode)
            LOAD_QUADWORD_DFORM:  is_load = 1'b1;
            STORE_QUADWORD_DFORM: is_store = 1'b1;
            LOAD_QUADWORD_AFORM:
            begin
                is_load = 1'b1;
                a_form = 1'b1;
            end
            STORE_QUADWORD_AFORM:
            begin
                is_store = 1'b1;
                a_form = 1'b1;
            end
            default: ;
        endcase
    end

    // I10 is a quadword offset, I16 a word address
    assign d_offset = {{18{issue.imm[6]}}, issue.imm[6:15], 4'b0000};
    assign a_offset = {{14{issue.imm[0]}}, issue.imm, 2'b00};

    assign ea = a_form ? a_offset : d_offset + issue.ra[0:WORD_BITS-1];

    assign ls_addr = ea[WORD_BITS-LS_ADDR_BITS +: LS_ADDR_BITS] & LSLR & QUAD_MASK;
    assign line = ls_addr[0 +: LS_LINE_BITS];

    always_ff @(posedge clock)
    begin
        if (issue_valid && is_store)
            mem[line] <= issue.store_data;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= issue_valid && (is_load || is_store);
    end

    // a store reports back with no register write
    always_ff @(posedge clock)
    begin
        if (issue_valid && (is_load || is_store))
        begin
            result.unit_id <= LOAD_STORE;
            result.rt_value <= is_load ? mem[line] : '0;
            result.wr_en <= is_load;
            result.rt_addr <= issue.rt_addr;
            result.latency <= LAT_LOAD_STORE;
        end
    end

endmodule

`default_nettype wire

// File: logic/credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module credit_counter
    import pipe_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic take,
    input  logic give,
    output logic has_credit
);

    credit_cnt_t count;

    // take and give in one cycle cancel out
    always_ff @(posedge clock)
    begin
        if (reset)
            count <= credit_cnt_t'(RESULT_CREDITS);
        else
        begin
            case ({take, give})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign has_credit = (count != '0);

endmodule

`default_nettype wire

// File: logic/odd_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  issue_t  in_instr,
    output logic    in_ready,
    output logic    out_valid,
    output result_t out_result,
    input  logic    result_credit
);

    logic    accept;
    logic    issue_valid;
    issue_t  issue;
    logic    perm_valid;
    result_t perm_result;
    logic    ls_valid;
    result_t ls_result;
    logic    merged_valid;
    result_t merged_result;

    assign accept = in_valid && in_ready;

    // each accepted instruction books a slot at the consumer
    credit_counter u_credit (
        .clock      (clock),
        .reset      (reset),
        .take       (accept),
        .give       (result_credit),
        .has_credit (in_ready)
    );

    always_ff @(posedge clock)
    begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= accept;
    end

    always_ff @(posedge clock)
    begin
        if (accept)
            issue <= in_instr;
    end

    // both units see every instruction and pick out their own opcodes
    permute_unit u_permute (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (perm_valid),
        .result       (perm_result)
    );

    ls_unit u_ls (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (ls_valid),
        .result       (ls_result)
    );

    // at most one unit reports in a cycle
    assign merged_valid = perm_valid || ls_valid;
    assign merged_result = result_t'((perm_valid ? perm_result : '0) |
                                     (ls_valid ? ls_result : '0));

    result_pipe u_forward (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (merged_valid),
        .in_result  (merged_result),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

// File: logic/result_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module result_pipe
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  result_t in_result,
    output logic    out_valid,
    output result_t out_result
);

    // stage 0 is the first register after the units
    logic [0:FORWARD_STAGES-1] valid_q;
    result_t                   stage_q [0:FORWARD_STAGES-1];

    always_ff @(posedge clock)
    begin
        if (reset)
            valid_q <= '0;
        else
            valid_q <= {in_valid, valid_q[0:FORWARD_STAGES-2]};
    end

    // records advance every cycle, the pipe never stalls
    always_ff @(posedge clock)
    begin
        stage_q[0] <= in_result;
        for (int i = 1; i < FORWARD_STAGES; i++)
            stage_q[i] <= stage_q[i-1];
    end

    assign out_valid = valid_q[FORWARD_STAGES-1];
    assign out_result = stage_q[FORWARD_STAGES-1];

endmodule

`default_nettype wire

// File: odd_pipe.f
common/isa_pkg.sv
common/pipe_pkg.sv
logic/credit_counter.sv
permute/permute_unit.sv
loadstore/ls_unit.sv
logic/result_pipe.sv
logic/odd_pipe.sv
verif/odd_pipe_chk.sv
verif/odd_pipe_tb.sv

// File: permute/permute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module permute_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    issue_valid,
    input  issue_t  issue,
    output logic    result_valid,
    output result_t result
);

    logic       is_perm;
    logic       rotate;
    logic       gather;
    logic [0:7] shift_amt;
    word_t      count_word;
    word_t      gather_bytes;
    word_t      gather_halves;
    word_t      gather_words;
    word_t      gather_word;
    quad_t      shifted;
    quad_t      rotated;
    quad_t      rt_value;

    // counts come from the leftmost word of rb
    assign count_word = issue.rb[0:WORD_BITS-1];

    // lsb of each element, element 0 ends up leftmost in the collected field
    always_comb
    begin
        gather_bytes = '0;
        gather_halves = '0;
        gather_words = '0;
        for (int j = 0; j < QUAD_BYTES; j++)
            gather_bytes[WORD_BITS - QUAD_BYTES + j] = issue.ra[j*BYTE_BITS + BYTE_BITS - 1];
        for (int j = 0; j < QUAD_BITS / HALF_BITS; j++)
            gather_halves[WORD_BITS - QUAD_BITS/HALF_BITS + j] =
                issue.ra[j*HALF_BITS + HALF_BITS - 1];
        for (int j = 0; j < QUAD_BITS / WORD_BITS; j++)
            gather_words[WORD_BITS - QUAD_BITS/WORD_BITS + j] =
                issue.ra[j*WORD_BITS + WORD_BITS - 1];
    end

    // every shift and rotate reduces to an amount in bits
    always_comb
    begin
        is_perm = 1'b1;
        rotate = 1'b0;
        gather = 1'b0;
        shift_amt = '0;
        gather_word = '0;
        case (issue.opcode)
            SHIFT_LEFT_QUADWORD_BY_BITS:           shift_amt = {5'b0, count_word[29:31]};
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE: shift_amt = {5'b0, issue.imm[13:15]};
            // byte counts up to 31 push everything out past 16
            SHIFT_LEFT_QUADWORD_BY_BYTES:          shift_amt = {count_word[27:31], 3'b000};
            SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE: shift_amt = {issue.imm[11:15], 3'b000};
            ROTATE_QUADWORD_BY_BYTES:
            begin
                rotate = 1'b1;
                shift_amt = {1'b0, count_word[28:31], 3'b000};
            end
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
            begin
                rotate = 1'b1;
                shift_amt = {1'b0, issue.imm[12:15], 3'b000};
            end
            ROTATE_QUADWORD_BY_BITS:
            begin
                rotate = 1'b1;
                shift_amt = {5'b0, count_word[29:31]};
            end
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
            begin
                rotate = 1'b1;
                shift_amt = {5'b0, issue.imm[13:15]};
            end
            GATHER_BITS_FROM_BYTES:
            begin
                gather = 1'b1;
                gather_word = gather_bytes;
            end
            GATHER_BITS_FROM_HALFWORDS:
            begin
                gather = 1'b1;
                gather_word = gather_halves;
            end
            GATHER_BITS_FROM_WORDS:
            begin
                gather = 1'b1;
                gather_word = gather_words;
            end
            default: is_perm = 1'b0;
        endcase
    end

    // left moves toward bit 0
    assign shifted = issue.ra << shift_amt;
    assign rotated = shifted | (issue.ra >> (QUAD_BITS - shift_amt));

    assign rt_value = gather ? {gather_word, {(QUAD_BITS - WORD_BITS){1'b0}}} :
                      rotate ? rotated : shifted;

    always_ff @(posedge clock)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= issue_valid && is_perm;
    end

    always_ff @(posedge clock)
    begin
        if (issue_valid && is_perm)
        begin
            result.unit_id <= PERMUTE;
            result.rt_value <= rt_value;
            result.wr_en <= 1'b1;
            result.rt_addr <= issue.rt_addr;
            result.latency <= LAT_PERMUTE;
        end
    end

endmodule

`default_nettype wire

// File: verif/odd_pipe_chk.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe_chk
    import pipe_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        in_valid,
    input logic        in_ready,
    input logic        issue_valid,
    input logic        out_valid,
    input credit_cnt_t credit_count
);

    logic accept;

    assign accept = in_valid && in_ready;

    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credit_count <= credit_cnt_t'(RESULT_CREDITS))
        else $error("credit count above the consumer buffer size");

    // a stalled input must not reach the issue register
    no_accept_when_full: assert property (@(posedge clock) disable iff (reset)
        !in_ready |=> !issue_valid)
        else $error("instruction taken while in_ready was low");

    result_follows_accept: assert property (@(posedge clock) disable iff (reset)
        accept |-> ##PIPE_LATENCY out_valid)
        else $error("accepted instruction gave no record after the pipe latency");

    accept_precedes_result: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> $past(accept, PIPE_LATENCY))
        else $error("record without an acceptance one pipe latency earlier");

endmodule

bind odd_pipe odd_pipe_chk u_chk (
    .clock        (clock),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .issue_valid  (issue_valid),
    .out_valid    (out_valid),
    .credit_count (u_credit.count)
);

`default_nettype wire

// File: verif/odd_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module odd_pipe_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int CLOCK_HALF = 20;
    localparam int RESET_CYCLES = 8;
    // about 40 instructions at no more than 8 cycles each, plus a wide margin
    localparam int MAX_CYCLES = 2000;

    logic    clock = 1'b0;
    logic    reset;
    logic    in_valid;
    issue_t  in_instr;
    logic    in_ready;
    logic    out_valid;
    result_t out_result;
    logic    result_credit = 1'b0;

    // scoreboard and the cycle in which each record is due
    result_t     exp_q [$];
    int          due_q [$];
    quad_t       shadow [0:LS_LINES-1];
    logic [31:0] rand_state = 32'h5cc6_3ae1;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          pending = 0;
    int          release_count = 0;
    logic        auto_credit = 1'b1;

    odd_pipe u_dut (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .result_credit (result_credit)
    );

    always #CLOCK_HALF clock = ~clock;

    always @(posedge clock)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // consumer side, returns one credit per record it has taken
    always @(negedge clock)
    begin
        if (!reset && out_valid)
        begin
            checks++;
            pending++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("ERR %0t: unexpected record %h", $time, out_result);
            end
            else
            begin
                if (out_result !== exp_q[0])
                begin
                    errors++;
                    $display("ERR %0t: got %h expected %h", $time, out_result, exp_q[0]);
                end
                if (cycles != due_q[0])
                begin
                    errors++;
                    $display("ERR %0t: record in cycle %0d, due in %0d", $time, cycles, due_q[0]);
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
        if ((auto_credit || release_count > 0) && pending > 0)
        begin
            result_credit = 1'b1;
            pending--;
            if (!auto_credit)
                release_count--;
        end
        else
            result_credit = 1'b0;
    end

    function automatic logic [31:0] next_random();
        rand_state ^= rand_state << 13;
        rand_state ^= rand_state >> 17;
        rand_state ^= rand_state << 5;
        return rand_state;
    endfunction

    function automatic quad_t random_quad();
        return {next_random(), next_random(), next_random(), next_random()};
    endfunction

    function automatic issue_t make_issue(opcode_e op, quad_t ra, quad_t rb, imm_t imm);
        issue_t s;
        s.opcode = op;
        s.ra = ra;
        s.rb = rb;
        s.store_data = random_quad();
        s.rt_addr = reg_addr_t'(next_random());
        s.imm = imm;
        return s;
    endfunction

    // bit 0 is the msb, so a left move takes bits from higher indices
    function automatic quad_t shift_left(quad_t a, int n);
        quad_t r;
        r = '0;
        for (int i = 0; i + n < QUAD_BITS; i++)
            r[i] = a[i + n];
        return r;
    endfunction

    function automatic quad_t rotate_left(quad_t a, int n);
        quad_t r;
        for (int i = 0; i < QUAD_BITS; i++)
            r[i] = a[(i + n) % QUAD_BITS];
        return r;
    endfunction

    function automatic quad_t gather_lsbs(quad_t a, int width);
        quad_t r;
        int    count;
        r = '0;
        count = QUAD_BITS / width;
        for (int j = 0; j < count; j++)
            r[WORD_BITS - count + j] = a[(j + 1) * width - 1];
        return r;
    endfunction

    function automatic int ls_address(issue_t s);
        logic [31:0] ea;
        if (s.opcode == LOAD_QUADWORD_AFORM || s.opcode == STORE_QUADWORD_AFORM)
            ea = {{16{s.imm[0]}}, s.imm} << 2;
        else
            ea = ({{22{s.imm[6]}}, s.imm[6:15]} << 4) + s.ra[0:WORD_BITS-1];
        ea = ea & 32'(LSLR);
        return int'(ea >> QUAD_ALIGN_BITS) << QUAD_ALIGN_BITS;
    endfunction

    function automatic result_t expected_for(issue_t s);
        result_t r;
        word_t   cw;
        cw = s.rb[0:WORD_BITS-1];
        r.unit_id = PERMUTE;
        r.wr_en = 1'b1;
        r.rt_addr = s.rt_addr;
        r.latency = LAT_PERMUTE;
        r.rt_value = '0;
        case (s.opcode)
            SHIFT_LEFT_QUADWORD_BY_BITS:
                r.rt_value = shift_left(s.ra, int'(cw[29:31]));
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                r.rt_value = shift_left(s.ra, int'(s.imm[13:15]));
            SHIFT_LEFT_QUADWORD_BY_BYTES:
                r.rt_value = shift_left(s.ra, 8 * int'(cw[27:31]));
            SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE:
                r.rt_value = shift_left(s.ra, 8 * int'(s.imm[11:15]));
            ROTATE_QUADWORD_BY_BYTES:
                r.rt_value = rotate_left(s.ra, 8 * int'(cw[28:31]));
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
                r.rt_value = rotate_left(s.ra, 8 * int'(s.imm[12:15]));
            ROTATE_QUADWORD_BY_BITS:
                r.rt_value = rotate_left(s.ra, int'(cw[29:31]));
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
                r.rt_value = rotate_left(s.ra, int'(s.imm[13:15]));
            GATHER_BITS_FROM_BYTES:     r.rt_value = gather_lsbs(s.ra, BYTE_BITS);
            GATHER_BITS_FROM_HALFWORDS: r.rt_value = gather_lsbs(s.ra, HALF_BITS);
            GATHER_BITS_FROM_WORDS:     r.rt_value = gather_lsbs(s.ra, WORD_BITS);
            default:
            begin
                r.unit_id = LOAD_STORE;
                r.latency = LAT_LOAD_STORE;
                if (s.opcode == STORE_QUADWORD_DFORM || s.opcode == STORE_QUADWORD_AFORM)
                    r.wr_en = 1'b0;
                else
                    r.rt_value = shadow[ls_address(s) >> QUAD_ALIGN_BITS];
            end
        endcase
        return r;
    endfunction

    // holds the instruction until it is accepted on the next rising edge
    task automatic send_instr(issue_t s, result_t exp);
        @(negedge clock);
        in_valid = 1'b1;
        in_instr = s;
        while (!in_ready)
            @(negedge clock);
        exp_q.push_back(exp);
        due_q.push_back(cycles + PIPE_LATENCY);
    endtask

    task automatic send_modeled(issue_t s);
        result_t exp;
        exp = expected_for(s);
        if (!exp.wr_en)
            shadow[ls_address(s) >> QUAD_ALIGN_BITS] = s.store_data;
        send_instr(s, exp);
    endtask

    task automatic drain_results();
        @(negedge clock);
        in_valid = 1'b0;
        while (exp_q.size() > 0)
            @(negedge clock);
    endtask

    task automatic check_ready(logic expected);
        checks++;
        if (in_ready !== expected)
        begin
            errors++;
            $display("ERR %0t: in_ready is %b, expected %b", $time, in_ready, expected);
        end
    endtask

    task automatic finish_test(string name, int errors_at_start);
        tests++;
        $display("test %s done with %0d errors", name, errors - errors_at_start);
    endtask

    task automatic run_reset_check();
        int start;
        start = errors;
        checks++;
        if (out_valid !== 1'b0)
        begin
            errors++;
            $display("ERR %0t: out_valid is %b after reset", $time, out_valid);
        end
        check_ready(1'b1);
        finish_test("reset state", start);
    endtask

    task automatic run_permute_tests();
        opcode_e ops [0:10] = '{
            SHIFT_LEFT_QUADWORD_BY_BITS, SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
            SHIFT_LEFT_QUADWORD_BY_BYTES, SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE,
            ROTATE_QUADWORD_BY_BYTES, ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
            ROTATE_QUADWORD_BY_BITS, ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
            GATHER_BITS_FROM_BYTES, GATHER_BITS_FROM_HALFWORDS, GATHER_BITS_FROM_WORDS};
        int start;
        start = errors;
        for (int round = 0; round < 2; round++)
            for (int k = 0; k < 11; k++)
                send_modeled(make_issue(ops[k], random_quad(), random_quad(),
                                        imm_t'(next_random())));
        // byte counts past the end of the quadword
        send_modeled(make_issue(SHIFT_LEFT_QUADWORD_BY_BYTES, random_quad(),
                                {32'd16, 96'b0}, '0));
        send_modeled(make_issue(SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE, random_quad(),
                                '0, 16'd31));
        drain_results();
        finish_test("permute results", start);
    endtask

    task automatic send_gather(opcode_e op, quad_t ra, word_t mask);
        issue_t  s;
        result_t exp;
        s = make_issue(op, ra, random_quad(), '0);
        exp = expected_for(s);
        exp.rt_value = {mask, 96'b0};
        send_instr(s, exp);
    endtask

    task automatic run_gather_tests();
        int    start;
        quad_t spread;
        start = errors;
        spread = 128'h00010000_00000001_00000000_01010101;
        send_gather(GATHER_BITS_FROM_BYTES, {16{8'h01}}, 32'h0000_ffff);
        send_gather(GATHER_BITS_FROM_HALFWORDS, {16{8'h01}}, 32'h0000_00ff);
        send_gather(GATHER_BITS_FROM_WORDS, {16{8'h01}}, 32'h0000_000f);
        send_gather(GATHER_BITS_FROM_BYTES, spread, 32'h0000_410f);
        send_gather(GATHER_BITS_FROM_HALFWORDS, spread, 32'h0000_0093);
        send_gather(GATHER_BITS_FROM_WORDS, spread, 32'h0000_0005);
        drain_results();
        finish_test("gathers", start);
    endtask

    task automatic run_store_load_tests();
        int          start;
        int          addr;
        logic [31:0] base;
        issue_t      st;
        issue_t      ld;
        start = errors;
        for (int k = 0; k < 4; k++)
        begin
            if (k % 2 == 0)
            begin
                // negative I10 on a full-width ra, read back through the a-form
                st = make_issue(STORE_QUADWORD_DFORM, random_quad(), '0,
                                {6'b0, 1'b1, 9'(next_random())});
                addr = ls_address(st);
                ld = make_issue(LOAD_QUADWORD_AFORM, '0, '0, imm_t'(addr >> 2));
            end
            else
            begin
                st = make_issue(STORE_QUADWORD_AFORM, '0, '0, {1'b1, 15'(next_random())});
                addr = ls_address(st);
                // bits above the local store size must be ignored
                base = (next_random() & 32'hffff_c000) | 32'(addr);
                ld = make_issue(LOAD_QUADWORD_DFORM, {base, 96'b0}, '0, '0);
            end
            send_modeled(st);
            send_modeled(ld);
        end
        drain_results();
        finish_test("store then load", start);
    endtask

    task automatic run_backpressure_test();
        int start;
        start = errors;
        auto_credit = 1'b0;
        repeat (2) @(negedge clock);
        check_ready(1'b1);
        for (int k = 0; k < RESULT_CREDITS; k++)
            send_modeled(make_issue(ROTATE_QUADWORD_BY_BITS, random_quad(), random_quad(), '0));
        fork
            send_modeled(make_issue(SHIFT_LEFT_QUADWORD_BY_BITS, random_quad(),
                                    random_quad(), '0));
            begin
                @(negedge clock);
                check_ready(1'b0);
                while (exp_q.size() > 0)
                    @(negedge clock);
                check_ready(1'b0);
                @(posedge clock);
                release_count = 1;
                @(negedge clock);
                check_ready(1'b0);
                @(negedge clock);
                check_ready(1'b1);
            end
        join
        auto_credit = 1'b1;
        drain_results();
        finish_test("credit back-pressure", start);
    endtask

    initial
    begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        run_reset_check();
        run_permute_tests();
        run_gather_tests();
        run_store_load_tests();
        run_backpressure_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
